//--- project.f
+incdir+logic
logic/midi_pkg.sv
logic/audio_pkg.sv
logic/uart_rx.sv
logic/midi_decoder.sv
logic/pulse_voice.sv
logic/sigma_delta_dac.sv
logic/midi_synth_top.sv
verification/midi_synth_properties.sv
verification/midi_synth_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MIDI synthesizer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module midi_synth_tb -Mdir obj_dir -o midi_synth_sim

status=0
./obj_dir/midi_synth_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

//--- verification/midi_synth_tb.sv
/* Directed testbench. Each serial bit lasts CLK_FREQ/BAUD_RATE cycles of the 4 ns clock,
   so the link runs faster than real MIDI while keeping the DUT's bit timing. */

`default_nettype none

`include "synth_params.svh"

module midi_synth_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import audio_pkg::*;

    localparam int CLKS_PER_BIT = `CLK_FREQ / `BAUD_RATE;
    localparam int MAX_CYCLES   = 40 * 10 * CLKS_PER_BIT + 200000;

    logic           clk;
    logic           reset;
    logic           rx;
    logic           dac_left;
    logic           dac_right;
    stereo_sample_t samples;
    logic           sample_valid;
    integer         seed = 32'h724e;
    int             errors = 0;
    int             checks = 0;
    int             cycles = 0;
    bit             run_reported = 1'b0;

    midi_synth_top u_midi_synth_top (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .dac_left     (dac_left),
        .dac_right    (dac_right),
        .samples      (samples),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            run_reported = 1'b1;
            $display("Timeout after %0d clock cycles, the tests did not complete", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Early end of the run, e.g. a failed assertion
    final begin
        if (!run_reported) begin
            $display("Run ended before all tests completed");
            $display("*** TEST FAILED ***");
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at time %0t: %s = %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_samples(input int left, input int right);
        check_value("samples.left", 32'(samples.left), left);
        check_value("samples.right", 32'(samples.right), right);
    endtask

    function automatic int limit_to(input int value, input int lo, input int hi);
        return (value < lo) ? lo : ((value > hi) ? hi : value);
    endfunction

    function automatic int random_velocity();
        return 1 + int'($unsigned($random(seed)) % 127);   // 1..127, never a note-off
    endfunction

    function automatic bit is_negative(input sample_t s);
        return s[`SAMPLE_W-1];
    endfunction

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        @(posedge clk);
        #1;
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
    endtask

    task automatic send_message(input logic [7:0] status, input logic [7:0] d0,
                                input logic [7:0] d1);
        send_byte(status);
        send_byte(d0);
        send_byte(d1);
    endtask

    task automatic wait_sample();
        do begin
            @(posedge clk);
            #1;
        end while (sample_valid !== 1'b1);
    endtask

    task automatic count_ones(input int n, output int ones_left, output int ones_right);
        ones_left  = 0;
        ones_right = 0;
        repeat (n) begin
            @(posedge clk);
            #1;
            if (dac_left === 1'b1) ones_left++;
            if (dac_right === 1'b1) ones_right++;
        end
    endtask

    // Length of the next negative half wave on the left side
    task automatic negative_run(output int length);
        length = 0;
        while (!is_negative(samples.left)) wait_sample();
        while (is_negative(samples.left)) begin
            length++;
            wait_sample();
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d mismatches", name, errors - start_errors);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_silence();
        int start = errors;
        int ones_left;
        int ones_right;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_value("sample_valid", 32'(sample_valid), 0);
        end
        reset = 1'b0;
        wait_sample();
        check_samples(0, 0);
        count_ones(4096, ones_left, ones_right);     // Zero sample sits at mid-scale
        check_value("dac_left ones", ones_left, limit_to(ones_left, 2040, 2056));
        check_value("dac_right ones", ones_right, limit_to(ones_right, 2040, 2056));
        report_test("reset and silence", start);
    endtask

    task automatic test_left_note();
        int start = errors;
        int vel;
        int length;
        vel = random_velocity();
        send_message(8'h90, 8'd100, 8'(vel));
        wait_sample();
        check_samples(vel * 1024, 0);
        negative_run(length);       // 128 - 100 samples per half
        check_value("negative half length", length, 28);
        length = 0;
        while (!is_negative(samples.left)) begin
            length++;
            wait_sample();
        end
        check_value("positive half length", length, 28);
        report_test("channel 0 note", start);
    endtask

    task automatic test_pan();
        int start = errors;
        int vel;
        vel = random_velocity();
        send_message(8'h91, 8'd60, 8'(vel));
        wait_sample();
        check_samples(0, vel * 1024);
        vel = random_velocity();
        send_message(8'h95, 8'd60, 8'(vel));
        wait_sample();
        check_samples(vel * 1024, vel * 1024);
        report_test("pan by channel", start);
    endtask

    task automatic test_running_status();
        int start = errors;
        int vel_a;
        int vel_b;
        int length;
        vel_a = random_velocity();
        vel_b = random_velocity();
        send_message(8'h90, 8'd60, 8'(vel_a));
        wait_sample();
        check_samples(vel_a * 1024, 0);
        send_byte(8'd120);          // No status byte, reuses note-on
        send_byte(8'(vel_b));
        wait_sample();
        check_samples(vel_b * 1024, 0);
        negative_run(length);
        check_value("negative half length", length, 8);
        report_test("running status", start);
    endtask

    task automatic test_note_off();
        int start = errors;
        int level;
        level = random_velocity() * 1024;
        send_message(8'h95, 8'd10, 8'(level / 1024));
        wait_sample();
        check_samples(level, level);
        send_message(8'h85, 8'd11, 8'd64);     // Other note
        wait_sample();
        check_samples(level, level);
        send_message(8'h85, 8'd10, 8'd64);
        wait_sample();
        check_samples(0, 0);
        send_message(8'h95, 8'd10, 8'(level / 1024));
        wait_sample();
        check_samples(level, level);
        send_message(8'h95, 8'd10, 8'd0);
        wait_sample();
        check_samples(0, 0);
        report_test("note off", start);
    endtask

    task automatic test_full_scale();
        int start = errors;
        int ones_left;
        int ones_right;
        send_message(8'h90, 8'd100, 8'd127);
        wait_sample();
        check_samples(127 * 1024, 0);
        count_ones(4096, ones_left, ones_right);
        check_value("dac_left ones", ones_left, limit_to(ones_left, 3501, 4096));
        // Right side is silent and stays at mid-scale
        check_value("dac_right ones", ones_right, limit_to(ones_right, 2040, 2056));
        report_test("full-scale density", start);
    endtask

    initial begin
        rx    = 1'b1;
        reset = 1'b1;
        test_reset_silence();
        test_left_note();
        test_pan();
        test_running_status();
        test_note_off();
        test_full_scale();
        run_reported = 1'b1;
        $display("Summary: %0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/midi_synth_properties.sv
/* Handshake and reset assertions for the synthesizer top. The byte and message strobes
   are internal nets reached through the bind. */

`default_nettype none

module midi_synth_properties (
    input wire logic                      clk,
    input wire logic                      reset,
    input wire logic                      byte_valid,
    input wire logic                      msg_valid,
    input wire logic                      sample_valid,
    input wire audio_pkg::stereo_sample_t samples
);
    timeunit 1ns;
    timeprecision 100ps;

    logic seen_msg;   // Any message decoded since reset

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_msg <= 1'b0;
        end else if (msg_valid) begin
            seen_msg <= 1'b1;
        end
    end

    // ----------------------------------------
    // Strobes
    // ----------------------------------------
    valids_low_in_reset: assert property (@(posedge clk)
        reset |=> !byte_valid && !msg_valid && !sample_valid)
        else $error("valid strobe high during reset");

    byte_valid_single: assert property (@(posedge clk) disable iff (reset)
        byte_valid |=> !byte_valid) else $error("byte_valid high for two cycles");

    msg_valid_single: assert property (@(posedge clk) disable iff (reset)
        msg_valid |=> !msg_valid) else $error("msg_valid high for two cycles");

    sample_valid_single: assert property (@(posedge clk) disable iff (reset)
        sample_valid |=> !sample_valid) else $error("sample_valid high for two cycles");

    // ----------------------------------------
    // Sample bus
    // ----------------------------------------
    samples_held: assert property (@(posedge clk) disable iff (reset)
        !sample_valid |-> $stable(samples)) else $error("samples changed between strobes");

    silent_until_msg: assert property (@(posedge clk) disable iff (reset)
        !seen_msg |-> samples == '0) else $error("samples nonzero before any message");

endmodule

bind midi_synth_top midi_synth_properties u_midi_synth_properties (
    .clk          (clk),
    .reset        (reset),
    .byte_valid   (byte_valid),
    .msg_valid    (msg_valid),
    .sample_valid (sample_valid),
    .samples      (samples)
);

`default_nettype wire

//--- logic/midi_synth_top.sv
/* MIDI in to stereo 1-bit audio on a single 100 MHz clock. The parallel sample bus is
   exported for a later codec. */

`default_nettype none

`include "synth_params.svh"

module midi_synth_top (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  rx,
    output logic                       dac_left,
    output logic                       dac_right,
    output audio_pkg::stereo_sample_t  samples,
    output logic                       sample_valid
);
    import midi_pkg::*;

    midi_byte_t byte_data;
    logic       byte_valid;
    midi_msg_t  msg;
    logic       msg_valid;

    uart_rx u_uart_rx (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    midi_decoder u_midi_decoder (
        .clk        (clk),
        .reset      (reset),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .msg        (msg),
        .msg_valid  (msg_valid)
    );

    pulse_voice u_pulse_voice (
        .clk          (clk),
        .reset        (reset),
        .msg          (msg),
        .msg_valid    (msg_valid),
        .samples      (samples),
        .sample_valid (sample_valid)
    );

    // One modulator per channel, both on the held sample
    sigma_delta_dac #(.MBITS(`DAC_MBITS)) u_dac_left (
        .clk    (clk),
        .reset  (reset),
        .sample (samples.left),
        .dout   (dac_left)
    );

    sigma_delta_dac #(.MBITS(`DAC_MBITS)) u_dac_right (
        .clk    (clk),
        .reset  (reset),
        .sample (samples.right),
        .dout   (dac_right)
    );

endmodule

`default_nettype wire

//--- logic/sigma_delta_dac.sv
/* First-order sigma-delta modulator. MBITS must not exceed SAMPLE_W; lower bits are dropped. */

`default_nettype none

`include "synth_params.svh"

module sigma_delta_dac #(
    parameter int MBITS = `DAC_MBITS
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire audio_pkg::sample_t sample,
    output logic                   dout
);

    logic [`SAMPLE_W-1:0] offset_sample;
    logic [MBITS-1:0]     acc;
    logic [MBITS:0]       sum;

    // Flip the sign bit, zero maps to mid-scale
    assign offset_sample = {~sample[`SAMPLE_W-1], sample[`SAMPLE_W-2:0]};

    assign sum = {1'b0, acc} + {1'b0, offset_sample[`SAMPLE_W-1 -: MBITS]};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc  <= '0;
            dout <= 1'b0;
        end else begin
            acc  <= sum[MBITS-1:0];
            dout <= sum[MBITS];   // Carry out is the pulse
        end
    end

endmodule

`default_nettype wire

//--- logic/pulse_voice.sv
/* Single square-wave voice with per-channel pan. A new note-on replaces the current note;
   samples only change on the sample strobe. */

`default_nettype none

`include "synth_params.svh"

module pulse_voice (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire midi_pkg::midi_msg_t   msg,
    input  wire logic                  msg_valid,
    output audio_pkg::stereo_sample_t  samples,
    output logic                       sample_valid
);
    import midi_pkg::*;
    import audio_pkg::*;

    localparam int DIV_W = $clog2(`SAMPLE_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic             active;
    logic             positive;     // Current half of the wave
    logic             pan_left;
    logic             pan_right;
    midi_data_t       note;
    sample_t          level;
    sample_t          wave;
    half_period_t     half_period;
    half_period_t     phase_cnt;
    logic [7:0]       hp_raw;
    logic             is_note_on;
    logic             is_note_off;

    assign tick = (div_cnt == DIV_W'(`SAMPLE_DIV - 1));

    // Note 0 would need 128, saturate to the 7-bit maximum
    assign hp_raw = 8'd128 - {1'b0, msg.data0};

    assign is_note_on  = (msg.cmd == cmd_note_on) && (msg.data1 != '0);
    assign is_note_off = ((msg.cmd == cmd_note_off) ||
                          (msg.cmd == cmd_note_on && msg.data1 == '0)) &&
                         (msg.data0 == note);

    assign wave = positive ? level : -level;

    // ----------------------------------------
    // Sample-rate timer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt      <= '0;
            sample_valid <= 1'b0;
        end else begin
            div_cnt      <= div_cnt + 1'b1;  // Wraps at SAMPLE_DIV
            sample_valid <= tick;
        end
    end

    // ----------------------------------------
    // Voice state and sample output
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            positive  <= 1'b1;
            phase_cnt <= '0;
            samples   <= '0;
        end else begin
            if (tick) begin
                samples.left  <= (active && pan_left)  ? wave : '0;
                samples.right <= (active && pan_right) ? wave : '0;
                if (phase_cnt == half_period - 1'b1) begin
                    phase_cnt <= '0;
                    positive  <= ~positive;
                end else begin
                    phase_cnt <= phase_cnt + 1'b1;
                end
            end

            if (msg_valid && is_note_on) begin
                active      <= 1'b1;
                note        <= msg.data0;
                level       <= {1'b0, msg.data1, 10'd0};   // Velocity times 1024
                half_period <= hp_raw[7] ? 7'd127 : hp_raw[6:0];
                pan_left    <= (msg.channel != 4'd1);
                pan_right   <= (msg.channel != 4'd0);
                positive    <= 1'b1;   // Restart on the positive half
                phase_cnt   <= '0;
            end else if (msg_valid && is_note_off) begin
                active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/midi_decoder.sv
/* Channel message decoder with running status. System bytes F0h and up cancel running
   status and are otherwise ignored. */

`default_nettype none

module midi_decoder (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire midi_pkg::midi_byte_t byte_data,
    input  wire logic                 byte_valid,
    output midi_pkg::midi_msg_t       msg,
    output logic                      msg_valid
);
    import midi_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_d0,
        st_wait_d1
    } dec_state_e;

    dec_state_e state;
    logic       run_valid;   // Running status held
    midi_cmd_e  run_cmd;
    midi_chan_t run_chan;
    midi_data_t data0_q;
    logic       one_data;

    // Program change and channel pressure carry one data byte
    assign one_data = (run_cmd == cmd_program) || (run_cmd == cmd_chan_pressure);

    always_ff @(posedge clk) begin
        msg_valid <= 1'b0;
        if (reset) begin
            state     <= st_idle;
            run_valid <= 1'b0;
        end else if (byte_valid) begin
            if (byte_data[7]) begin
                // ----------------------------------------
                // Status byte
                // ----------------------------------------
                if (byte_data[7:4] == 4'hF) begin
                    run_valid <= 1'b0;
                    state     <= st_idle;
                end else begin
                    run_cmd   <= midi_cmd_e'(byte_data[6:4]);
                    run_chan  <= byte_data[3:0];
                    run_valid <= 1'b1;
                    state     <= st_wait_d0;
                end
            end else begin
                // ----------------------------------------
                // Data byte
                // ----------------------------------------
                case (state)
                    st_idle, st_wait_d0: begin
                        if (run_valid) begin  // Idle here means running status reuse
                            data0_q <= byte_data[6:0];
                            if (one_data) begin
                                msg.cmd     <= run_cmd;
                                msg.channel <= run_chan;
                                msg.data0   <= byte_data[6:0];
                                msg.data1   <= '0;
                                msg_valid   <= 1'b1;
                                state       <= st_idle;
                            end else begin
                                state <= st_wait_d1;
                            end
                        end
                    end
                    default: begin  // st_wait_d1
                        msg.cmd     <= run_cmd;
                        msg.channel <= run_chan;
                        msg.data0   <= data0_q;
                        msg.data1   <= byte_data[6:0];
                        msg_valid   <= 1'b1;
                        state       <= st_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
/* 8N1 serial receiver, LSB first. A byte with a low stop bit is dropped without notice. */

`default_nettype none

`include "synth_params.svh"

module uart_rx (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 rx,
    output midi_pkg::midi_byte_t      byte_data,
    output logic                      byte_valid
);
    import midi_pkg::*;

    localparam int CLKS_PER_BIT = `CLK_FREQ / `BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_sync;
    midi_byte_t       shift_reg;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        byte_valid <= 1'b0;
        if (reset) begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    baud_cnt <= '0;
                    if (!rx_sync) state <= st_start;   // Falling edge of start bit
                end
                st_start: begin
                    if (baud_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? st_idle : st_data;  // Glitch rejection
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        baud_cnt  <= '0;
                        shift_reg <= {rx_sync, shift_reg[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin  // st_stop
                    if (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        byte_valid <= rx_sync;
                        state      <= st_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign byte_data = shift_reg;  // Held until the next byte shifts in

endmodule

`default_nettype wire

//--- logic/audio_pkg.sv
/* Audio sample types. Sample width follows SAMPLE_W from the params header. */

`default_nettype none

`include "synth_params.svh"

package audio_pkg;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_sample_t;

    // Samples per half wave of the square voice
    typedef logic [6:0] half_period_t;

endpackage

`default_nettype wire

//--- logic/midi_pkg.sv
/* MIDI byte and channel message types. Only channel voice messages are represented. */

`default_nettype none

package midi_pkg;

    typedef logic [7:0] midi_byte_t;
    typedef logic [6:0] midi_data_t;   // Data byte payload, MSB stripped
    typedef logic [3:0] midi_chan_t;

    // Low three bits of the status nibble, 8h..Eh
    typedef enum logic [2:0] {
        cmd_note_off      = 3'd0,
        cmd_note_on       = 3'd1,
        cmd_poly_pressure = 3'd2,
        cmd_control       = 3'd3,
        cmd_program       = 3'd4,
        cmd_chan_pressure = 3'd5,
        cmd_pitch_bend    = 3'd6
    } midi_cmd_e;

    typedef struct packed {
        midi_cmd_e  cmd;
        midi_chan_t channel;
        midi_data_t data0;   // Note number or first parameter
        midi_data_t data1;   // Velocity, zero for one-byte messages
    } midi_msg_t;

endpackage

`default_nettype wire

//--- logic/synth_params.svh
/* Build constants for the MIDI synthesizer. CLK_FREQ must be a whole multiple of BAUD_RATE,
   and SAMPLE_DIV a power of two. */

`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// ----------------------------------------
// Clocking and serial link
// ----------------------------------------
`define CLK_FREQ   100000000  // System clock in Hz
`define BAUD_RATE  31250      // MIDI serial rate

// ----------------------------------------
// Audio path
// ----------------------------------------
`define SAMPLE_DIV 2048       // Clocks per audio sample
`define SAMPLE_W   18         // Signed sample width
`define DAC_MBITS  16         // Accumulator width in each modulator

`endif
